/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mem_hier
LINT_TOP   := mem_hier
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
verilog/mem_pkg.sv
verilog/line_arbiter.sv
verilog/l2_cache.sv
verilog/victim_cache.sv
verilog/miss_router.sv
verilog/mem_hier.sv
tb/pmem_model.sv
tb/tb_mem_hier.sv

/* tb/pmem_model.sv */
module pmem_model (
	input  logic                pmembus,
	input  logic                rst_n,
	input  logic                stall,
	input  logic                mem_valid,
	input  logic                mem_we,
	input  mem_pkg::line_addr_t mem_addr,
	input  mem_pkg::line_t      mem_wdata,
	output logic                mem_ready,
	output logic                mem_rvalid,
	output mem_pkg::line_t      mem_rdata,
	output int                  read_count,
	output int                  write_count
);
	timeunit 1ns;
	timeprecision 1ps;

	mem_pkg::line_t store_q [1 << mem_pkg::LINE_ADDR_W];  // whole line address space.
	logic [1:0] wait_q;                                   // cycles left on the open read.
	mem_pkg::line_addr_t rd_addr_q;

	function automatic mem_pkg::line_t line_pattern(input mem_pkg::line_addr_t a);
		logic [31:0] h;
		h = {20'h5A3C9, a} * 32'h9E37_79B1;             // spread every address bit.
		return {h ^ 32'h0F0F_0000, h + 32'h1, ~h, {a, 20'hC3A51}};
	endfunction

	assign mem_ready = !stall && (wait_q == 2'd0);      // busy while a read is open.

	always @(posedge pmembus)
	begin
		if (!rst_n)
		begin
			wait_q <= 2'd0;
			mem_rvalid <= 1'b0;
			read_count <= 0;
			write_count <= 0;
			for (int a = 0; a < (1 << mem_pkg::LINE_ADDR_W); a++)
				store_q[mem_pkg::line_addr_t'(a)] <= line_pattern(mem_pkg::line_addr_t'(a));
		end
		else
		begin
			mem_rvalid <= 1'b0;
			if (wait_q != 2'd0)
			begin
				wait_q <= wait_q - 2'd1;
				if (wait_q == 2'd1)
				begin
					mem_rvalid <= 1'b1;                 // one-cycle data pulse.
					mem_rdata <= store_q[rd_addr_q];
				end
			end
			if (mem_valid && mem_ready)
			begin
				if (mem_we)
				begin
					store_q[mem_addr] <= mem_wdata;
					write_count <= write_count + 1;
				end
				else
				begin
					rd_addr_q <= mem_addr;
					wait_q <= 2'd2;                     // data seen 3 cycles after the transfer.
					read_count <= read_count + 1;
				end
			end
		end
	end

endmodule : pmem_model

/* tb/tb_mem_hier.sv */
module tb_mem_hier;
	timeunit 1ns;
	timeprecision 1ps;

	logic pmembus = 1'b0;
	logic rst_n;
	logic i_req_valid, i_req_ready, i_resp_valid;
	logic d_req_valid, d_we, d_req_ready, d_resp_valid;
	mem_pkg::line_addr_t i_addr, d_addr;
	mem_pkg::line_t i_rdata, d_rdata, d_wdata;
	logic mem_valid, mem_we, mem_ready, mem_rvalid, mem_stall;
	mem_pkg::line_addr_t mem_addr;
	mem_pkg::line_t mem_wdata, mem_rdata;
	int read_count, write_count;

	mem_pkg::line_t shadow [mem_pkg::line_addr_t];  // last written data per line.
	mem_pkg::line_addr_t wb_addrs [$];              // every memory write seen.
	logic [31:0] rnd_q, stall_rnd_q;
	string test_name;
	int cycle, issued;
	int hs_i, hs_d, lat_i, lat_d;                   // handshake cycle and last latency.
	int pass_i, pass_d;                             // grants lost while waiting.
	mem_pkg::line_t exp_i, exp_d;

	mem_hier mem_hier_i (.*);

	pmem_model pmem_model_i (
		.pmembus, .rst_n, .stall(mem_stall),
		.mem_valid, .mem_we, .mem_addr, .mem_wdata,
		.mem_ready, .mem_rvalid, .mem_rdata, .read_count, .write_count
	);

	always #10 pmembus = ~pmembus;  // 20 ns period.

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] rand_word();
		rnd_q = xorshift32(rnd_q);
		return rnd_q;
	endfunction

	function automatic mem_pkg::line_t rand_line();
		return {rand_word(), rand_word(), rand_word(), rand_word()};
	endfunction

	function automatic mem_pkg::line_t line_pattern(input mem_pkg::line_addr_t a);
		logic [31:0] h;
		h = {20'h5A3C9, a} * 32'h9E37_79B1;
		return {h ^ 32'h0F0F_0000, h + 32'h1, ~h, {a, 20'hC3A51}};
	endfunction

	// expected line content: last write, else the memory's start value.
	function automatic mem_pkg::line_t ref_line(input mem_pkg::line_addr_t a);
		if (shadow.exists(a))
			return shadow[a];
		return line_pattern(a);
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_equal(input string what, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act)
			fail_now($sformatf("error %s %s: expected %h, actual %h", test_name, what, exp, act));
	endtask

	task automatic read_i(input mem_pkg::line_addr_t a);
		issued++;
		i_addr = a;
		i_req_valid = 1'b1;
		do @(posedge pmembus); while (!i_req_ready);  // hold until the transfer.
		#1 i_req_valid = 1'b0;
		do @(posedge pmembus); while (!i_resp_valid);
		#1;
	endtask

	task automatic access_d(input logic we, input mem_pkg::line_addr_t a, input mem_pkg::line_t data);
		issued++;
		d_addr = a;
		d_we = we;
		d_wdata = data;
		d_req_valid = 1'b1;
		do @(posedge pmembus); while (!d_req_ready);
		#1 d_req_valid = 1'b0;
		do @(posedge pmembus); while (!d_resp_valid);
		#1;
	endtask

	// random back-pressure on the memory port, about one cycle in eight.
	always @(posedge pmembus)
	begin
		#1;
		stall_rnd_q = xorshift32(stall_rnd_q);
		mem_stall = (stall_rnd_q[2:0] == 3'd0);
	end

	// compare process. expected data is fixed in handshake order.
	always @(posedge pmembus)
	begin
		if (rst_n)
		begin
			if (i_req_valid && i_req_ready)
			begin
				exp_i = ref_line(i_addr);
				hs_i = cycle;
				pass_i = 0;
				if (d_req_valid)
					pass_d++;                             // data side lost this grant.
			end
			if (d_req_valid && d_req_ready)
			begin
				if (d_we)
					shadow[d_addr] = d_wdata;
				exp_d = ref_line(d_addr);
				hs_d = cycle;
				pass_d = 0;
				if (i_req_valid)
					pass_i++;
			end
			if (pass_i > 1)
				fail_now("instruction port was passed over by two data grants");
			if (pass_d > 1)
				fail_now("data port was passed over by two instruction grants");
			if (i_resp_valid)
			begin
				check_equal("i_rdata", exp_i, i_rdata);
				lat_i = cycle - hs_i;
			end
			if (d_resp_valid)
			begin
				check_equal("d_rdata", exp_d, d_rdata);
				lat_d = cycle - hs_d;
			end
			if (mem_valid && mem_we && mem_ready)
				wb_addrs.push_back(mem_addr);
		end
		if (cycle > 60 * issued + 200)
			fail_now("timeout, the memory hierarchy stopped answering requests");
		cycle++;
	end

	initial
	begin
		logic [31:0] w;
		int rc;
		int wc;
		int n;
		mem_pkg::line_addr_t a1, a2, wa;
		mem_pkg::line_t data;
		mem_pkg::line_addr_t i_list [8];
		mem_pkg::line_addr_t d_list [8];
		logic d_we_list [8];
		mem_pkg::line_t d_data_list [8];
		rst_n = 1'b0;
		i_req_valid = 1'b0;
		i_addr = '0;
		d_req_valid = 1'b0;
		d_addr = '0;
		d_we = 1'b0;
		d_wdata = '0;
		mem_stall = 1'b0;
		rnd_q = 32'd88148;
		stall_rnd_q = 32'd88148 ^ 32'h5555_5555;     // second stream from the same seed.
		cycle = 0;
		issued = 0;
		pass_i = 0;
		pass_d = 0;
		repeat (2) @(posedge pmembus);
		#1 rst_n = 1'b1;

		test_name = "reset";
		@(posedge pmembus);
		check_equal("i_req_ready", 128'(i_req_ready), 128'(1));
		check_equal("d_req_ready", 128'(d_req_ready), 128'(1));
		check_equal("i_resp_valid", 128'(i_resp_valid), 128'(0));
		check_equal("d_resp_valid", 128'(d_resp_valid), 128'(0));
		check_equal("mem_valid", 128'(mem_valid), 128'(0));
		#1;
		test_name = "first read";
		read_i(12'h010);
		access_d(1'b0, 12'h021, '0);
		read_i(12'h932);

		test_name = "write then read";
		access_d(1'b1, 12'h044, rand_line());
		read_i(12'h044);
		access_d(1'b0, 12'h044, '0);

		test_name = "random mix";
		repeat (60)
		begin
			w = rand_word();
			a1 = {4'h0, w[15:8]};                       // 16 sets by 16 tags.
			a2 = {4'h0, w[23:16]};
			data = rand_line();
			repeat (w[3:2]) #20;
			case (w[1:0])
				2'd0: read_i(a1);
				2'd1: access_d(w[4], a2, data);
				default:
				begin
					fork
						read_i(a1);
						access_d(w[4], a2, data);
					join
				end
			endcase
		end

		test_name = "hit timing";
		read_i(12'h377);
		rc = read_count;
		wc = write_count;
		read_i(12'h377);
		check_equal("i hit latency", 128'(lat_i), 128'(2));
		access_d(1'b0, 12'h377, '0);
		check_equal("d hit latency", 128'(lat_d), 128'(2));
		check_equal("memory reads", 128'(rc), 128'(read_count));
		check_equal("memory writes", 128'(wc), 128'(write_count));

		test_name = "victim hit";
		for (int t = 0; t < 5; t++)
			read_i({8'hA0 + 8'(t), 4'h3});            // five tags in set 3.
		rc = read_count;
		read_i({8'hA1, 4'h3});
		read_i({8'hA3, 4'h3});
		check_equal("memory reads", 128'(rc), 128'(read_count));

		test_name = "dirty writeback";
		wb_addrs.delete();
		for (int t = 0; t < 7; t++)
			access_d(1'b1, {8'hF0 + 8'(t), 4'h5}, rand_line());
		read_i({8'hF5, 4'h5});                         // dirty swap-back from the victim cache.
		n = 0;
		foreach (wb_addrs[k])
		begin
			wa = wb_addrs[k];
			if (wa[3:0] == 4'h5 && wa[11:8] == 4'hF)
			begin
				n++;
				check_equal("memory line", ref_line(wa), pmem_model_i.store_q[wa]);
			end
		end
		if (n < 2)
			fail_now("dirty lines of set 5 were never written to memory");

		test_name = "both ports";
		for (int k = 0; k < 8; k++)
		begin
			w = rand_word();
			i_list[k] = {4'h2, w[7:0]};
			d_list[k] = w[9] ? i_list[k] : {4'h2, w[19:12]};  // sometimes the same line.
			d_we_list[k] = w[8];
			d_data_list[k] = rand_line();
		end
		// each port streams back to back, so every grant is contested.
		fork
			begin
				for (int k = 0; k < 8; k++)
					read_i(i_list[k]);
			end
			begin
				for (int k = 0; k < 8; k++)
					access_d(d_we_list[k], d_list[k], d_data_list[k]);
			end
		join

		$display("TEST PASSED");
		$finish;
	end

endmodule : tb_mem_hier

/* verilog/l2_cache.sv */
module l2_cache (
	input  logic                pmembus,
	input  logic                rst_n,
	input  logic                req_valid,
	input  mem_pkg::line_addr_t addr,
	input  logic                we,
	input  mem_pkg::line_t      wdata,
	output logic                req_ready,
	output logic                resp_valid,
	output mem_pkg::line_t      rdata,
	output logic                miss_valid,
	output mem_pkg::line_addr_t miss_addr,
	output logic                evict_valid,
	output mem_pkg::line_addr_t evict_addr,
	output mem_pkg::line_t      evict_data,
	output logic                evict_dirty,
	input  logic                fill_valid,
	input  mem_pkg::line_t      fill_data
);

	mem_pkg::l2_state_t state_q;

	logic [mem_pkg::L2_SETS-1:0] valid_q;
	logic [mem_pkg::L2_SETS-1:0] dirty_q;
	mem_pkg::l2_tag_t tag_q [mem_pkg::L2_SETS];
	mem_pkg::line_t data_q [mem_pkg::L2_SETS];

	mem_pkg::line_addr_t addr_q;  // the request being served.
	logic we_q;
	mem_pkg::line_t wdata_q;
	mem_pkg::line_t rdata_q;

	mem_pkg::l2_index_t idx;
	mem_pkg::l2_tag_t tag;
	logic hit;
	mem_pkg::line_t new_line;

	assign idx = addr_q[mem_pkg::L2_INDEX_W-1:0];
	assign tag = addr_q[mem_pkg::LINE_ADDR_W-1:mem_pkg::L2_INDEX_W];
	assign hit = valid_q[idx] && (tag_q[idx] == tag);
	assign new_line = we_q ? wdata_q : fill_data;  // a write miss replaces the whole line.

	assign req_ready = (state_q == mem_pkg::L2_IDLE);
	assign resp_valid = (state_q == mem_pkg::L2_RESPOND);
	assign rdata = rdata_q;

	// victim goes out together with the miss, clean or dirty.
	assign miss_valid = (state_q == mem_pkg::L2_EVICT);
	assign miss_addr = addr_q;
	assign evict_valid = miss_valid && valid_q[idx];
	assign evict_addr = {tag_q[idx], idx};
	assign evict_data = data_q[idx];
	assign evict_dirty = dirty_q[idx];

	always_ff @(posedge pmembus)
	begin
		if (!rst_n)
		begin
			state_q <= mem_pkg::L2_IDLE;
			valid_q <= '0;
			dirty_q <= '0;
		end
		else
		begin
			case (state_q)
				mem_pkg::L2_IDLE:
				begin
					if (req_valid)
						state_q <= mem_pkg::L2_LOOKUP;
				end
				mem_pkg::L2_LOOKUP:
				begin
					if (hit)
					begin
						if (we_q)
							dirty_q[idx] <= 1'b1;  // write hit.
						state_q <= mem_pkg::L2_RESPOND;
					end
					else
					begin
						state_q <= mem_pkg::L2_EVICT;
					end
				end
				mem_pkg::L2_EVICT:
				begin
					state_q <= mem_pkg::L2_FILL;       // router has latched the miss.
				end
				mem_pkg::L2_FILL:
				begin
					if (fill_valid)
					begin
						valid_q[idx] <= 1'b1;
						dirty_q[idx] <= we_q;          // a merged write leaves it dirty.
						state_q <= mem_pkg::L2_RESPOND;
					end
				end
				mem_pkg::L2_RESPOND:
				begin
					state_q <= mem_pkg::L2_IDLE;
				end
				default:
				begin
					state_q <= mem_pkg::L2_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge pmembus)
	begin
		if (state_q == mem_pkg::L2_IDLE && req_valid)
		begin
			addr_q <= addr;
			we_q <= we;
			wdata_q <= wdata;
		end
		if (state_q == mem_pkg::L2_LOOKUP && hit)
		begin
			if (we_q)
				data_q[idx] <= wdata_q;
			rdata_q <= we_q ? wdata_q : data_q[idx];  // a write echoes its own line.
		end
		if (state_q == mem_pkg::L2_FILL && fill_valid)
		begin
			tag_q[idx] <= tag;
			data_q[idx] <= new_line;
			rdata_q <= new_line;
		end
	end

endmodule : l2_cache

/* verilog/line_arbiter.sv */
module line_arbiter (
	input  logic                pmembus,
	input  logic                rst_n,
	input  logic                i_req_valid,
	input  mem_pkg::line_addr_t i_addr,
	output logic                i_req_ready,
	output logic                i_resp_valid,
	output mem_pkg::line_t      i_rdata,
	input  logic                d_req_valid,
	input  mem_pkg::line_addr_t d_addr,
	input  logic                d_we,
	input  mem_pkg::line_t      d_wdata,
	output logic                d_req_ready,
	output logic                d_resp_valid,
	output mem_pkg::line_t      d_rdata,
	output logic                l2_req_valid,
	output mem_pkg::line_addr_t l2_addr,
	output logic                l2_we,
	output mem_pkg::line_t      l2_wdata,
	input  logic                l2_req_ready,
	input  logic                l2_resp_valid,
	input  mem_pkg::line_t      l2_rdata
);

	logic prio_q;   // set when the data port has first pick.
	logic owner_q;  // set when the data port owns the open request.
	logic grant_d;
	logic grant_i;

	assign grant_d = d_req_valid && (prio_q || !i_req_valid);  // data wins on its turn or alone.
	assign grant_i = i_req_valid && !grant_d;

	assign l2_req_valid = i_req_valid || d_req_valid;
	assign l2_addr = grant_d ? d_addr : i_addr;
	assign l2_we = grant_d && d_we;                             // instruction side never writes.
	assign l2_wdata = d_wdata;

	// a port is ready unless the other one holds the grant.
	assign i_req_ready = l2_req_ready && !grant_d;
	assign d_req_ready = l2_req_ready && !grant_i;

	assign i_resp_valid = l2_resp_valid && !owner_q;            // steer back to the winner.
	assign d_resp_valid = l2_resp_valid && owner_q;
	assign i_rdata = l2_rdata;
	assign d_rdata = l2_rdata;

	always_ff @(posedge pmembus)
	begin
		if (!rst_n)
		begin
			prio_q <= 1'b0;
			owner_q <= 1'b0;
		end
		else if (l2_req_valid && l2_req_ready)
		begin
			owner_q <= grant_d;                                 // remember who gets the answer.
			prio_q <= grant_i;                                  // loser goes first next time.
		end
	end

endmodule : line_arbiter

/* verilog/mem_hier.sv */
module mem_hier (
	input  logic                pmembus,
	input  logic                rst_n,
	input  logic                i_req_valid,
	input  mem_pkg::line_addr_t i_addr,
	output logic                i_req_ready,
	output logic                i_resp_valid,
	output mem_pkg::line_t      i_rdata,
	input  logic                d_req_valid,
	input  mem_pkg::line_addr_t d_addr,
	input  logic                d_we,
	input  mem_pkg::line_t      d_wdata,
	output logic                d_req_ready,
	output logic                d_resp_valid,
	output mem_pkg::line_t      d_rdata,
	output logic                mem_valid,
	output logic                mem_we,
	output mem_pkg::line_addr_t mem_addr,
	output mem_pkg::line_t      mem_wdata,
	input  logic                mem_ready,
	input  logic                mem_rvalid,
	input  mem_pkg::line_t      mem_rdata
);

	logic l2_req_valid;           // arbiter to l2.
	logic l2_req_ready;
	logic l2_we;
	logic l2_resp_valid;
	mem_pkg::line_addr_t l2_addr;
	mem_pkg::line_t l2_wdata;
	mem_pkg::line_t l2_rdata;

	logic miss_valid;             // l2 to router.
	logic evict_valid;
	logic evict_dirty;
	logic fill_valid;
	mem_pkg::line_addr_t miss_addr;
	mem_pkg::line_addr_t evict_addr;
	mem_pkg::line_t evict_data;
	mem_pkg::line_t fill_data;

	logic lookup_valid;           // router to victim cache.
	logic lookup_hit;
	logic insert_valid;
	logic insert_ready;
	logic insert_dirty;
	logic wb_valid;
	logic wb_done;
	mem_pkg::line_addr_t lookup_addr;
	mem_pkg::line_addr_t insert_addr;
	mem_pkg::line_addr_t wb_addr;
	mem_pkg::line_t lookup_data;
	mem_pkg::line_t insert_data;
	mem_pkg::line_t wb_data;

	line_arbiter line_arbiter_i (
		.pmembus, .rst_n,
		.i_req_valid, .i_addr, .i_req_ready, .i_resp_valid, .i_rdata,
		.d_req_valid, .d_addr, .d_we, .d_wdata, .d_req_ready, .d_resp_valid, .d_rdata,
		.l2_req_valid, .l2_addr, .l2_we, .l2_wdata,
		.l2_req_ready, .l2_resp_valid, .l2_rdata
	);

	l2_cache l2_cache_i (
		.pmembus, .rst_n,
		.req_valid(l2_req_valid), .addr(l2_addr), .we(l2_we), .wdata(l2_wdata),
		.req_ready(l2_req_ready), .resp_valid(l2_resp_valid), .rdata(l2_rdata),
		.miss_valid, .miss_addr,
		.evict_valid, .evict_addr, .evict_data, .evict_dirty,
		.fill_valid, .fill_data
	);

	victim_cache victim_cache_i (
		.pmembus, .rst_n,
		.lookup_valid, .lookup_addr, .lookup_hit, .lookup_data,
		.insert_valid, .insert_addr, .insert_data, .insert_dirty, .insert_ready,
		.wb_valid, .wb_addr, .wb_data, .wb_done
	);

	miss_router miss_router_i (
		.pmembus, .rst_n,
		.miss_valid, .miss_addr,
		.evict_valid, .evict_addr, .evict_data, .evict_dirty,
		.fill_valid, .fill_data,
		.lookup_valid, .lookup_addr, .lookup_hit, .lookup_data,
		.insert_valid, .insert_addr, .insert_data, .insert_dirty, .insert_ready,
		.wb_valid, .wb_addr, .wb_data, .wb_done,
		.mem_valid, .mem_we, .mem_addr, .mem_wdata,
		.mem_ready, .mem_rvalid, .mem_rdata
	);

endmodule : mem_hier

/* verilog/mem_pkg.sv */
package mem_pkg;

	localparam int LINE_ADDR_W = 12;                     // line address width.
	localparam int LINE_W = 128;                         // bits per cache line.
	localparam int L2_INDEX_W = 4;                       // low address bits pick the set.
	localparam int L2_TAG_W = LINE_ADDR_W - L2_INDEX_W;  // the rest is tag.
	localparam int VC_SLOT_W = 2;
	localparam int L2_SETS = 1 << L2_INDEX_W;            // 16 sets.
	localparam int VC_ENTRIES = 1 << VC_SLOT_W;          // 4 victim entries.

	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [L2_INDEX_W-1:0] l2_index_t;
	typedef logic [L2_TAG_W-1:0] l2_tag_t;
	typedef logic [VC_SLOT_W-1:0] vc_slot_t;             // also used as an age rank.

	typedef enum logic [2:0] {
		L2_IDLE,
		L2_LOOKUP,
		L2_EVICT,                                        // one cycle, hands the miss to the router.
		L2_FILL,
		L2_RESPOND
	} l2_state_t;

	typedef enum logic [2:0] {
		RT_IDLE,
		RT_VC_LOOKUP,                                    // insert the victim, then probe.
		RT_MEM_READ,
		RT_MEM_WRITE,
		RT_DONE
	} route_state_t;

endpackage : mem_pkg

/* verilog/miss_router.sv */
module miss_router (
	input  logic                pmembus,
	input  logic                rst_n,
	input  logic                miss_valid,
	input  mem_pkg::line_addr_t miss_addr,
	input  logic                evict_valid,
	input  mem_pkg::line_addr_t evict_addr,
	input  mem_pkg::line_t      evict_data,
	input  logic                evict_dirty,
	output logic                fill_valid,
	output mem_pkg::line_t      fill_data,
	output logic                lookup_valid,
	output mem_pkg::line_addr_t lookup_addr,
	input  logic                lookup_hit,
	input  mem_pkg::line_t      lookup_data,
	output logic                insert_valid,
	output mem_pkg::line_addr_t insert_addr,
	output mem_pkg::line_t      insert_data,
	output logic                insert_dirty,
	input  logic                insert_ready,
	input  logic                wb_valid,
	input  mem_pkg::line_addr_t wb_addr,
	input  mem_pkg::line_t      wb_data,
	output logic                wb_done,
	output logic                mem_valid,
	output logic                mem_we,
	output mem_pkg::line_addr_t mem_addr,
	output mem_pkg::line_t      mem_wdata,
	input  logic                mem_ready,
	input  logic                mem_rvalid,
	input  mem_pkg::line_t      mem_rdata
);

	mem_pkg::route_state_t state_q;
	logic ins_pend_q;             // victim still has to go into the victim cache.
	logic sent_q;                 // probe or memory read already issued.
	logic hit_q;                  // line came from the victim cache.
	mem_pkg::line_addr_t miss_addr_q;
	mem_pkg::line_addr_t ev_addr_q;
	mem_pkg::line_t ev_data_q;
	logic ev_dirty_q;
	mem_pkg::line_t fill_q;
	logic lk_result;

	assign lk_result = (state_q == mem_pkg::RT_VC_LOOKUP) && !ins_pend_q && sent_q;

	// insert is held across the writeback so the victim cache keeps wb_valid up.
	assign insert_valid = ins_pend_q &&
		(state_q == mem_pkg::RT_VC_LOOKUP || state_q == mem_pkg::RT_MEM_WRITE);
	assign insert_addr = ev_addr_q;
	assign insert_data = ev_data_q;
	assign insert_dirty = ev_dirty_q;
	assign lookup_valid = (state_q == mem_pkg::RT_VC_LOOKUP) && !ins_pend_q && !sent_q;
	assign lookup_addr = miss_addr_q;

	assign mem_we = (state_q == mem_pkg::RT_MEM_WRITE);
	assign mem_valid = mem_we || (state_q == mem_pkg::RT_MEM_READ && !sent_q);
	assign mem_addr = mem_we ? wb_addr : miss_addr_q;
	assign mem_wdata = wb_data;
	assign wb_done = mem_we && mem_ready;

	assign fill_valid = (state_q == mem_pkg::RT_DONE);
	assign fill_data = fill_q;

	always_ff @(posedge pmembus)
	begin
		if (!rst_n)
		begin
			state_q <= mem_pkg::RT_IDLE;
			ins_pend_q <= 1'b0;
			sent_q <= 1'b0;
			hit_q <= 1'b0;
		end
		else
		begin
			case (state_q)
				mem_pkg::RT_IDLE:
				begin
					if (miss_valid)
					begin
						ins_pend_q <= evict_valid;
						sent_q <= 1'b0;
						hit_q <= 1'b0;
						state_q <= mem_pkg::RT_VC_LOOKUP;
					end
				end
				mem_pkg::RT_VC_LOOKUP:
				begin
					if (ins_pend_q)
					begin
						if (insert_ready)
							ins_pend_q <= 1'b0;
						else
							state_q <= mem_pkg::RT_MEM_WRITE;  // displaced dirty line first.
					end
					else if (!sent_q)
					begin
						sent_q <= 1'b1;
					end
					else
					begin
						sent_q <= 1'b0;
						if (lookup_hit)
						begin
							hit_q <= 1'b1;
							// a dirty swap-back is written out so the fill is clean.
							state_q <= wb_valid ? mem_pkg::RT_MEM_WRITE : mem_pkg::RT_DONE;
						end
						else
						begin
							state_q <= mem_pkg::RT_MEM_READ;
						end
					end
				end
				mem_pkg::RT_MEM_WRITE:
				begin
					if (mem_ready)
						state_q <= hit_q ? mem_pkg::RT_DONE : mem_pkg::RT_VC_LOOKUP;
				end
				mem_pkg::RT_MEM_READ:
				begin
					if (mem_valid && mem_ready)
						sent_q <= 1'b1;
					if (sent_q && mem_rvalid)
					begin
						sent_q <= 1'b0;
						state_q <= mem_pkg::RT_DONE;
					end
				end
				default:
				begin
					state_q <= mem_pkg::RT_IDLE;                // done, fill pulse went out.
				end
			endcase
		end
	end

	always_ff @(posedge pmembus)
	begin
		if (state_q == mem_pkg::RT_IDLE && miss_valid)
		begin
			miss_addr_q <= miss_addr;
			ev_addr_q <= evict_addr;
			ev_data_q <= evict_data;
			ev_dirty_q <= evict_dirty;
		end
		if (lk_result && lookup_hit)
			fill_q <= lookup_data;
		if (state_q == mem_pkg::RT_MEM_READ && sent_q && mem_rvalid)
			fill_q <= mem_rdata;
	end

endmodule : miss_router

/* verilog/victim_cache.sv */
module victim_cache (
	input  logic                pmembus,
	input  logic                rst_n,
	input  logic                lookup_valid,
	input  mem_pkg::line_addr_t lookup_addr,
	output logic                lookup_hit,
	output mem_pkg::line_t      lookup_data,
	input  logic                insert_valid,
	input  mem_pkg::line_addr_t insert_addr,
	input  mem_pkg::line_t      insert_data,
	input  logic                insert_dirty,
	output logic                insert_ready,
	output logic                wb_valid,
	output mem_pkg::line_addr_t wb_addr,
	output mem_pkg::line_t      wb_data,
	input  logic                wb_done
);

	logic [mem_pkg::VC_ENTRIES-1:0] valid_q;
	logic [mem_pkg::VC_ENTRIES-1:0] dirty_q;
	mem_pkg::line_addr_t addr_q [mem_pkg::VC_ENTRIES];
	mem_pkg::line_t data_q [mem_pkg::VC_ENTRIES];
	mem_pkg::vc_slot_t age_q [mem_pkg::VC_ENTRIES];  // 0 is newest, ranks stay packed.

	logic pend_q;                   // a dirty hit waits for its writeback.
	mem_pkg::vc_slot_t pend_slot_q;
	logic hit_q;
	mem_pkg::line_t hit_data_q;

	logic hit_any;
	logic has_free;
	logic ins_en;
	logic rel_en;
	mem_pkg::vc_slot_t hit_slot;
	mem_pkg::vc_slot_t free_slot;
	mem_pkg::vc_slot_t old_slot;
	mem_pkg::vc_slot_t ins_slot;
	mem_pkg::vc_slot_t wb_slot;
	mem_pkg::vc_slot_t rel_slot;

	always_comb
	begin
		hit_any = 1'b0;
		hit_slot = '0;
		has_free = 1'b0;
		free_slot = '0;
		old_slot = '0;
		for (int i = 0; i < mem_pkg::VC_ENTRIES; i++)
		begin
			if (valid_q[i] && addr_q[i] == lookup_addr)
			begin
				hit_any = 1'b1;
				hit_slot = mem_pkg::vc_slot_t'(i);
			end
			if (!valid_q[i])
			begin
				has_free = 1'b1;
				free_slot = mem_pkg::vc_slot_t'(i);
			end
			if (valid_q[i] && age_q[i] == mem_pkg::vc_slot_t'(mem_pkg::VC_ENTRIES - 1))
				old_slot = mem_pkg::vc_slot_t'(i);  // only meaningful when full.
		end
	end

	assign ins_slot = has_free ? free_slot : old_slot;
	assign insert_ready = has_free || !dirty_q[old_slot];  // dirty oldest must go to memory first.
	assign ins_en = insert_valid && insert_ready;

	assign wb_slot = pend_q ? pend_slot_q : old_slot;
	assign wb_valid = pend_q || (insert_valid && !has_free && dirty_q[old_slot]);
	assign wb_addr = addr_q[wb_slot];
	assign wb_data = data_q[wb_slot];

	// clean hits leave at once, dirty ones after their writeback.
	assign rel_en = (lookup_valid && hit_any && !dirty_q[hit_slot]) || (wb_done && pend_q);
	assign rel_slot = pend_q ? pend_slot_q : hit_slot;

	assign lookup_hit = hit_q;
	assign lookup_data = hit_data_q;

	always_ff @(posedge pmembus)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
			pend_q <= 1'b0;
			pend_slot_q <= '0;
			hit_q <= 1'b0;
			for (int i = 0; i < mem_pkg::VC_ENTRIES; i++)
				age_q[i] <= '0;
		end
		else
		begin
			hit_q <= lookup_valid && hit_any;
			if (ins_en)
			begin
				for (int i = 0; i < mem_pkg::VC_ENTRIES; i++)
				begin
					if (mem_pkg::vc_slot_t'(i) == ins_slot)
					begin
						valid_q[i] <= 1'b1;
						dirty_q[i] <= insert_dirty;
						age_q[i] <= '0;
					end
					else if (valid_q[i])
					begin
						age_q[i] <= age_q[i] + mem_pkg::vc_slot_t'(1);  // everyone else ages by one.
					end
				end
			end
			if (rel_en)
			begin
				valid_q[rel_slot] <= 1'b0;
				pend_q <= 1'b0;
				for (int i = 0; i < mem_pkg::VC_ENTRIES; i++)
				begin
					if (valid_q[i] && age_q[i] > age_q[rel_slot])
						age_q[i] <= age_q[i] - mem_pkg::vc_slot_t'(1);  // close the gap.
				end
			end
			if (lookup_valid && hit_any && dirty_q[hit_slot])
			begin
				pend_q <= 1'b1;
				pend_slot_q <= hit_slot;
			end
			if (wb_done && !pend_q)
				dirty_q[old_slot] <= 1'b0;         // displaced line now safe in memory.
		end
	end

	always_ff @(posedge pmembus)
	begin
		if (ins_en)
		begin
			addr_q[ins_slot] <= insert_addr;
			data_q[ins_slot] <= insert_data;
		end
		if (lookup_valid)
			hit_data_q <= data_q[hit_slot];
	end

endmodule : victim_cache
